// ==== md_config.svh ====
`ifndef MD_CONFIG_SVH
`define MD_CONFIG_SVH

// cells served by one broadcast controller
`define NUM_CELLS 4

// particle index and count width
`define PARTICLE_ID_WIDTH 7

// idle cycles between iter_start and the count cycle
`define START_WAIT_CYCLES 10

// pair slots per reader filter buffer
`define FILTER_DEPTH 8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the broadcast testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module md_broadcast_tb -f sim.f -o md_broadcast_sim

# keep running after an assertion error so the testbench can report
./obj_dir/md_broadcast_sim +verilator+error+limit+1000 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== sim.f ====
+incdir+.
verilog/md_pkg.sv
verilog/cell_count_bank.sv
verilog/broadcast_controller.sv
verilog/cell_reader.sv
verilog/md_broadcast_top.sv
tb/md_broadcast_checker.sv
tb/md_broadcast_tb.sv

// ==== tb/md_broadcast_checker.sv ====
`timescale 1ns/10ps

module md_broadcast_checker
(
	input logic clk,
	input logic rst,
	input logic iter_start,
	input md_pkg::bcast_t bcast,
	input md_pkg::ctrl_state_t state,
	input logic any_back_pressure,
	input logic all_broadcast_done
);

	import md_pkg::*;

	// assertion failures so far, read by the testbench at the end
	int unsigned fail_count = 0;

	// high once the first iter_start after reset is seen
	logic started;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			started <= 1'b0;
		end
		else if (iter_start)
		begin
			started <= 1'b1;
		end
	end

	// idle word until the first start
	idle_paused: assert property (@(posedge clk) disable iff (rst)
		!started |-> bcast.pause_reading)
	else
	begin
		fail_count++;
		$error("broadcast word valid before the first iter_start");
	end

	// count cycle is a single-cycle flag
	count_cycle_single: assert property (@(posedge clk) disable iff (rst)
		bcast.reading_particle_num |=> !bcast.reading_particle_num)
	else
	begin
		fail_count++;
		$error("reading_particle_num high for two cycles");
	end

	// neighbor id frozen under back-pressure, except at the end of a sweep
	id_held: assert property (@(posedge clk) disable iff (rst)
		(state == reading && any_back_pressure && !all_broadcast_done)
		|=> $stable(bcast.particle_id))
	else
	begin
		fail_count++;
		$error("particle_id moved under back-pressure");
	end

endmodule

bind broadcast_controller md_broadcast_checker i_md_broadcast_checker
(
	.clk(clk),
	.rst(rst),
	.iter_start(iter_start),
	.bcast(bcast),
	.state(state),
	.any_back_pressure(any_back_pressure),
	.all_broadcast_done(all_broadcast_done)
);

// ==== tb/md_broadcast_tb.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module md_broadcast_tb;

	import md_pkg::*;

	localparam int NC = `NUM_CELLS;
	localparam int MAX_ID = 1 << `PARTICLE_ID_WIDTH;
	localparam int NUM_ROWS = 4;

	// one test case with cell 0 count in the low bits
	typedef struct packed {
		logic [NC-1:0][`PARTICLE_ID_WIDTH-1:0] counts;
		logic [7:0] pop_pct;
		logic [15:0] force_cycle;
		logic stray_start;
	} test_row_t;

	// counts listed cell 3 first
	// stray_start pulses iter_start during the force hold
	localparam test_row_t ROWS [NUM_ROWS] = '{
		'{{7'd0, 7'd1, 7'd5, 7'd3}, 8'd50, 16'd0, 1'b0},
		'{{7'd0, 7'd4, 7'd2, 7'd6}, 8'd10, 16'd0, 1'b0},
		'{{7'd1, 7'd0, 7'd3, 7'd2}, 8'd50, 16'd500, 1'b1},
		'{{7'd0, 7'd2, 7'd7, 7'd1}, 8'd100, 16'd0, 1'b0}
	};

	logic clk;
	logic rst;
	logic count_wr;
	cell_idx_t count_wr_cell;
	particle_id_t count_wr_value;
	logic iter_start;
	logic all_force_wr_issued;
	logic [NC-1:0] pair_pop;
	logic [NC-1:0] pair_valid;
	pair_t [NC-1:0] pair_head;
	logic all_reading_done;
	logic all_filter_buffer_empty;

	int err_cnt;
	int assert_fails;
	// pairs popped per cell by ref_id and particle_id
	bit got [NC][MAX_ID][MAX_ID];
	int got_cnt [NC];

	md_broadcast_top i_md_broadcast_top (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ordered pair of distinct particles in 1..cnt where phase picks the order
	function automatic bit pair_legal(int cnt, int r, int p, int ph);
		if (p < 1 || p > cnt || r < 1 || r > cnt)
			return 1'b0;
		return (ph != 0) ? (p < r) : (p > r);
	endfunction

	function automatic int watchdog_cycles();
		int total;
		int mx;
		total = 1000;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			mx = 0;
			for (int c = 0; c < NC; c++)
			begin
				if (int'(ROWS[r].counts[c]) > mx)
					mx = int'(ROWS[r].counts[c]);
			end
			// sweep length stretched by slow pops
			total += mx * mx * 4 * (100 / int'(ROWS[r].pop_pct));
		end
		return total;
	endfunction

	task automatic check_pop(int c, int cnt);
		int r;
		int p;
		int ph;
		r = int'(pair_head[c].ref_id);
		p = int'(pair_head[c].particle_id);
		ph = int'(pair_head[c].phase);
		if (!pair_legal(cnt, r, p, ph))
		begin
			err_cnt++;
			$display("FAIL pair_head[%0d] illegal ref_id %h particle_id %h phase %h count %h",
				c, r, p, ph, cnt);
		end
		else if (got[c][r][p])
		begin
			err_cnt++;
			$display("FAIL pair_head[%0d] duplicate ref_id %h particle_id %h", c, r, p);
		end
		else
		begin
			got[c][r][p] = 1'b1;
			got_cnt[c]++;
		end
	endtask

	task automatic write_counts(int row);
		for (int c = 0; c < NC; c++)
		begin
			@(posedge clk);
			count_wr <= 1'b1;
			count_wr_cell <= cell_idx_t'(c);
			count_wr_value <= ROWS[row].counts[c];
		end
		@(posedge clk);
		count_wr <= 1'b0;
	endtask

	task automatic run_row(int row);
		int cyc;
		int pct;
		int cnt [NC];
		logic [NC-1:0] prev_valid;
		logic [NC-1:0] prev_pop;
		logic [NC-1:0] drained;
		pair_t [NC-1:0] prev_head;
		bit done_seen;
		bit exit_seen;
		bit stray_sent;
		bit stray_fire;
		cyc = 0;
		pct = int'(ROWS[row].pop_pct);
		prev_valid = '0;
		prev_pop = '0;
		drained = '0;
		prev_head = '0;
		done_seen = 1'b0;
		exit_seen = 1'b0;
		stray_sent = 1'b0;
		for (int c = 0; c < NC; c++)
		begin
			cnt[c] = int'(ROWS[row].counts[c]);
			got_cnt[c] = 0;
			for (int r = 0; r < MAX_ID; r++)
				for (int p = 0; p < MAX_ID; p++)
					got[c][r][p] = 1'b0;
		end
		write_counts(row);
		@(negedge clk);
		if (pair_valid !== '0 || all_reading_done !== 1'b0)
		begin
			err_cnt++;
			$display("FAIL before iter_start pair_valid %h all_reading_done %h",
				pair_valid, all_reading_done);
		end
		@(posedge clk);
		iter_start <= 1'b1;
		while (!(exit_seen && all_filter_buffer_empty))
		begin
			@(posedge clk);
			// second start while the controller holds for force writes
			stray_fire = ROWS[row].stray_start && done_seen && !stray_sent
				&& (cyc < int'(ROWS[row].force_cycle));
			stray_sent = stray_sent || stray_fire;
			iter_start <= stray_fire;
			all_force_wr_issued <= (cyc >= int'(ROWS[row].force_cycle));
			for (int c = 0; c < NC; c++)
				pair_pop[c] <= (($urandom % 100) < pct);
			@(negedge clk);
			cyc++;
			if (all_reading_done)
				done_seen = 1'b1;
			for (int c = 0; c < NC; c++)
			begin
				// an entry that was not popped must still be at the head
				if (prev_valid[c] && !prev_pop[c] && !pair_valid[c])
				begin
					err_cnt++;
					$display("FAIL pair_valid[%0d] %h expected 1", c, pair_valid[c]);
				end
				else if (prev_valid[c] && !prev_pop[c] && pair_head[c] !== prev_head[c])
				begin
					err_cnt++;
					$display("FAIL pair_head[%0d] %h expected %h", c, pair_head[c], prev_head[c]);
				end
				// nothing before the first data word and nothing once done and drained
				if (pair_valid[c] && (cyc < `START_WAIT_CYCLES + 2 || drained[c]))
				begin
					err_cnt++;
					$display("FAIL pair_valid[%0d] %h expected 0 at cycle %0d",
						c, pair_valid[c], cyc);
				end
				if (pair_pop[c] && pair_valid[c])
					check_pop(c, cnt[c]);
				if (done_seen && !pair_valid[c])
					drained[c] = 1'b1;
				prev_valid[c] = pair_valid[c];
				prev_pop[c] = pair_pop[c];
				prev_head[c] = pair_head[c];
			end
			if (all_reading_done && all_force_wr_issued)
				exit_seen = 1'b1;
		end
		@(posedge clk);
		pair_pop <= '0;
		iter_start <= 1'b0;
		all_force_wr_issued <= 1'b0;
		for (int c = 0; c < NC; c++)
		begin
			if (got_cnt[c] != cnt[c] * (cnt[c] - 1))
			begin
				err_cnt++;
				$display("FAIL pair count cell %0d got %h expected %h",
					c, got_cnt[c], cnt[c] * (cnt[c] - 1));
			end
		end
		if (ROWS[row].stray_start && !stray_sent)
		begin
			err_cnt++;
			$display("row %0d never reached the hold for force writes", row);
		end
		// a swallowed start must not launch an iteration
		repeat (`START_WAIT_CYCLES + 8)
		begin
			@(negedge clk);
			if (pair_valid !== '0)
			begin
				err_cnt++;
				$display("FAIL pair_valid %h expected 0 while idle", pair_valid);
			end
		end
	endtask

	initial
	begin
		void'($urandom(88));
		err_cnt = 0;
		rst <= 1'b1;
		count_wr <= 1'b0;
		count_wr_cell <= '0;
		count_wr_value <= '0;
		iter_start <= 1'b0;
		all_force_wr_issued <= 1'b0;
		pair_pop <= '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (pair_valid !== '0 || all_filter_buffer_empty !== 1'b1)
		begin
			err_cnt++;
			$display("FAIL after reset pair_valid %h all_filter_buffer_empty %h",
				pair_valid, all_filter_buffer_empty);
		end
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		assert_fails = int'(
			i_md_broadcast_top.i_broadcast_controller.i_md_broadcast_checker.fail_count);
		$display("errors: %0d testbench, %0d assertion", err_cnt, assert_fails);
		if (err_cnt == 0 && assert_fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog with a budget from the table
	initial
	begin
		repeat (watchdog_cycles()) @(posedge clk);
		$display("timeout: run did not end within %0d cycles", watchdog_cycles());
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== verilog/broadcast_controller.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module broadcast_controller
(
	input logic clk,
	input logic rst,
	input logic iter_start,
	input md_pkg::particle_id_t [`NUM_CELLS-1:0] cell_counts,
	input logic [`NUM_CELLS-1:0] back_pressure,
	input logic [`NUM_CELLS-1:0] filter_buffer_empty,
	input logic [`NUM_CELLS-1:0] reading_done,
	input logic all_force_wr_issued,
	output md_pkg::bcast_t bcast,
	output logic all_reading_done,
	output logic all_filter_buffer_empty
);

	import md_pkg::*;

	// start-up counter sized for 0..START_WAIT_CYCLES
	localparam int WAIT_BITS = $clog2(`START_WAIT_CYCLES + 1);
	localparam int WAIT_WIDTH = (WAIT_BITS > 0) ? WAIT_BITS : 1;
	localparam logic [WAIT_WIDTH-1:0] WAIT_LAST = WAIT_WIDTH'(`START_WAIT_CYCLES);

	ctrl_state_t state;
	logic [WAIT_WIDTH-1:0] wait_cnt;

	// per cell, current neighbor id has reached that cell's count
	logic [`NUM_CELLS-1:0] broadcast_done;
	logic all_broadcast_done;
	logic any_back_pressure;

	always_comb
	begin
		for (int i = 0; i < `NUM_CELLS; i++)
		begin
			broadcast_done[i] = (bcast.particle_id >= cell_counts[i]);
		end
	end

	// reductions of the per-cell flags
	assign all_broadcast_done = &broadcast_done;
	assign any_back_pressure = |back_pressure;
	assign all_reading_done = &reading_done;
	assign all_filter_buffer_empty = &filter_buffer_empty;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= wait_for_start;
			wait_cnt <= '0;
			bcast.particle_id <= '0;
			bcast.ref_id <= particle_id_t'(1);
			bcast.phase <= 1'b0;
			bcast.reading_particle_num <= 1'b0;
			bcast.pause_reading <= 1'b1;
		end
		else
		begin
			case (state)
				wait_for_start:
				begin
					// idle word, first reference preloaded
					bcast.ref_id <= particle_id_t'(1);
					bcast.phase <= 1'b0;
					bcast.particle_id <= '0;
					// countdown runs on once started
					if (iter_start || wait_cnt != '0)
					begin
						if (wait_cnt == WAIT_LAST)
						begin
							state <= read_particle_num;
							wait_cnt <= '0;
							bcast.pause_reading <= 1'b0;
							// count cycle flag, single cycle
							bcast.reading_particle_num <= 1'b1;
						end
						else
						begin
							wait_cnt <= wait_cnt + 1'b1;
							bcast.pause_reading <= 1'b1;
							bcast.reading_particle_num <= 1'b0;
						end
					end
					else
					begin
						bcast.pause_reading <= 1'b1;
						bcast.reading_particle_num <= 1'b0;
					end
				end
				read_particle_num:
				begin
					// first real word is ref 1, neighbor 1, phase 0
					state <= reading;
					bcast.ref_id <= particle_id_t'(1);
					bcast.particle_id <= bcast.particle_id + 1'b1;
					bcast.reading_particle_num <= 1'b0;
					bcast.pause_reading <= 1'b0;
				end
				reading:
				begin
					bcast.reading_particle_num <= 1'b0;
					if (all_broadcast_done)
					begin
						// every cell saw its last neighbor, flip phase
						bcast.phase <= ~bcast.phase;
						bcast.particle_id <= particle_id_t'(1);
						if (!bcast.phase)
						begin
							// same reference, phase 1 next
							bcast.pause_reading <= 1'b0;
						end
						else
						begin
							// next reference once buffers drain
							state <= wait_next_ref;
							bcast.ref_id <= bcast.ref_id + 1'b1;
							bcast.pause_reading <= 1'b1;
						end
					end
					else if (any_back_pressure)
					begin
						// hold id and invalidate, word already sent once
						bcast.pause_reading <= 1'b1;
					end
					else
					begin
						bcast.particle_id <= bcast.particle_id + 1'b1;
						bcast.pause_reading <= 1'b0;
					end
				end
				wait_next_ref:
				begin
					bcast.reading_particle_num <= 1'b0;
					if (all_reading_done)
					begin
						// iteration over, leave only with force writes issued
						bcast.pause_reading <= 1'b1;
						if (all_force_wr_issued)
						begin
							state <= wait_for_start;
							bcast.ref_id <= particle_id_t'(1);
							bcast.phase <= 1'b0;
							bcast.particle_id <= '0;
						end
					end
					else if (all_filter_buffer_empty)
					begin
						state <= reading;
						bcast.pause_reading <= 1'b0;
					end
					else
					begin
						bcast.pause_reading <= 1'b1;
					end
				end
				default:
				begin
					state <= wait_for_start;
					bcast.pause_reading <= 1'b1;
					bcast.reading_particle_num <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== verilog/cell_count_bank.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module cell_count_bank
(
	input logic clk,
	input logic rst,
	input logic count_wr,
	input md_pkg::cell_idx_t count_wr_cell,
	input md_pkg::particle_id_t count_wr_value,
	output md_pkg::particle_id_t [`NUM_CELLS-1:0] cell_counts
);

	import md_pkg::*;

	// one-hot write select, index out of range hits nothing
	logic [`NUM_CELLS-1:0] wr_hit;

	// count registers behind the output array
	particle_id_t [`NUM_CELLS-1:0] count_q;

	always_comb
	begin
		for (int i = 0; i < `NUM_CELLS; i++)
		begin
			wr_hit[i] = count_wr && (count_wr_cell == cell_idx_t'(i));
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// empty cells until the host writes counts
			count_q <= '0;
		end
		else
		begin
			for (int i = 0; i < `NUM_CELLS; i++)
			begin
				if (wr_hit[i])
				begin
					count_q[i] <= count_wr_value;
				end
			end
		end
	end

	// new count visible the cycle after the strobe
	assign cell_counts = count_q;

endmodule

// ==== verilog/cell_reader.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module cell_reader
(
	input logic clk,
	input logic rst,
	input md_pkg::bcast_t bcast,
	input md_pkg::particle_id_t cell_count,
	input logic pair_pop,
	output logic pair_valid,
	output md_pkg::pair_t pair_head,
	output logic back_pressure,
	output logic filter_buffer_empty,
	output logic reading_done
);

	import md_pkg::*;

	localparam int DEPTH = `FILTER_DEPTH;
	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int FILL_WIDTH = $clog2(DEPTH + 1);
	// three slots of margin for the controller's registered reaction
	localparam logic [FILL_WIDTH-1:0] BP_LEVEL = FILL_WIDTH'(DEPTH - 3);
	localparam logic [FILL_WIDTH-1:0] FULL_LEVEL = FILL_WIDTH'(DEPTH);
	localparam logic [PTR_WIDTH-1:0] PTR_LAST = PTR_WIDTH'(DEPTH - 1);

	pair_t buf_mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [FILL_WIDTH-1:0] fill;

	logic word_accept;
	logic id_in_range;
	logic ref_in_range;
	logic phase_ok;
	logic push;
	logic pop;
	pair_t pair_in;

	// valid data word, not paused and not the count cycle
	assign word_accept = !bcast.pause_reading && !bcast.reading_particle_num;

	// neighbor 1..count, reference at most count
	assign id_in_range = (bcast.particle_id != '0) && (bcast.particle_id <= cell_count);
	assign ref_in_range = (bcast.ref_id <= cell_count);

	// phase 0 takes higher neighbors, phase 1 lower ones
	assign phase_ok = bcast.phase ? (bcast.particle_id < bcast.ref_id)
		: (bcast.particle_id > bcast.ref_id);

	assign push = word_accept && id_in_range && ref_in_range && phase_ok
		&& (fill != FULL_LEVEL);

	// pop on empty buffer is dropped
	assign pop = pair_pop && (fill != '0);

	always_comb
	begin
		pair_in.ref_id = bcast.ref_id;
		pair_in.particle_id = bcast.particle_id;
		pair_in.phase = bcast.phase;
	end

	// pair storage
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			buf_mem[wr_ptr] <= pair_in;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop)
			begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// head of queue, shown the cycle after the push
	assign pair_head = buf_mem[rd_ptr];
	assign pair_valid = (fill != '0);
	assign filter_buffer_empty = (fill == '0);
	assign back_pressure = (fill >= BP_LEVEL);

	// references past this cell's count give no more pairs
	assign reading_done = (bcast.ref_id > cell_count);

endmodule

// ==== verilog/md_broadcast_top.sv ====
`timescale 1ns/10ps
`include "md_config.svh"

module md_broadcast_top
(
	input logic clk,
	input logic rst,
	input logic count_wr,
	input md_pkg::cell_idx_t count_wr_cell,
	input md_pkg::particle_id_t count_wr_value,
	input logic iter_start,
	input logic all_force_wr_issued,
	input logic [`NUM_CELLS-1:0] pair_pop,
	output logic [`NUM_CELLS-1:0] pair_valid,
	output md_pkg::pair_t [`NUM_CELLS-1:0] pair_head,
	output logic all_reading_done,
	output logic all_filter_buffer_empty
);

	import md_pkg::*;

	// counts from the bank, fanned out to controller and readers
	particle_id_t [`NUM_CELLS-1:0] cell_counts;

	// shared broadcast word
	bcast_t bcast;

	// per-cell status back to the controller
	logic [`NUM_CELLS-1:0] back_pressure;
	logic [`NUM_CELLS-1:0] filter_buffer_empty;
	logic [`NUM_CELLS-1:0] reading_done;

	cell_count_bank i_cell_count_bank
	(
		.clk(clk),
		.rst(rst),
		.count_wr(count_wr),
		.count_wr_cell(count_wr_cell),
		.count_wr_value(count_wr_value),
		.cell_counts(cell_counts)
	);

	broadcast_controller i_broadcast_controller
	(
		.clk(clk),
		.rst(rst),
		.iter_start(iter_start),
		.cell_counts(cell_counts),
		.back_pressure(back_pressure),
		.filter_buffer_empty(filter_buffer_empty),
		.reading_done(reading_done),
		.all_force_wr_issued(all_force_wr_issued),
		.bcast(bcast),
		.all_reading_done(all_reading_done),
		.all_filter_buffer_empty(all_filter_buffer_empty)
	);

	// one reader per cell
	for (genvar i = 0; i < `NUM_CELLS; i++)
	begin : g_cell
		cell_reader i_cell_reader
		(
			.clk(clk),
			.rst(rst),
			.bcast(bcast),
			.cell_count(cell_counts[i]),
			.pair_pop(pair_pop[i]),
			.pair_valid(pair_valid[i]),
			.pair_head(pair_head[i]),
			.back_pressure(back_pressure[i]),
			.filter_buffer_empty(filter_buffer_empty[i]),
			.reading_done(reading_done[i])
		);
	end

endmodule

// ==== verilog/md_pkg.sv ====
`include "md_config.svh"

package md_pkg;

	// index of a cell in the bank, at least one bit wide
	localparam int CELL_IDX_WIDTH = (`NUM_CELLS > 1) ? $clog2(`NUM_CELLS) : 1;

	typedef logic [CELL_IDX_WIDTH-1:0] cell_idx_t;

	// particle index inside a cell, also used for counts
	typedef logic [`PARTICLE_ID_WIDTH-1:0] particle_id_t;

	// one word per cycle from the controller to every cell
	typedef struct packed {
		particle_id_t particle_id;
		particle_id_t ref_id;
		logic phase;
		// high only in the count cycle
		logic reading_particle_num;
		// word carries nothing when high
		logic pause_reading;
	} bcast_t;

	// candidate pair held in a filter buffer
	typedef struct packed {
		particle_id_t ref_id;
		particle_id_t particle_id;
		logic phase;
	} pair_t;

	typedef enum logic [1:0] {
		wait_for_start,
		read_particle_num,
		reading,
		wait_next_ref
	} ctrl_state_t;

endpackage
